// ==== common/nnPkg.sv ====
package nnPkg;

	// ############################################################
	// number format and layer sizes
	// ############################################################

	localparam int dataWidth = 16;
	localparam int fracBits = 8;

	localparam int numInputs = 10;
	localparam int numHidden = 10;
	localparam int numOutputs = 4;
	localparam int maxFanIn = 10;

	// Q8.8 signed value
	typedef logic signed [dataWidth-1:0] activationT;

	// lanes above a layer's width stay zero
	typedef activationT [maxFanIn-1:0] activationVecT;

	// ############################################################
	// fixed weights and biases
	// ############################################################

	// hidden layer, one row per neuron, one column per input
	localparam activationT hiddenWeights [numHidden][numInputs] = '{
		'{16'sh003d, 16'shffa2, 16'sh0058, 16'sh0021, 16'shff8c,
			16'sh0070, 16'sh0012, 16'shffd6, 16'sh0044, 16'sh0009},
		'{16'shffc1, 16'sh0063, 16'sh0017, 16'shff9e, 16'sh0035,
			16'sh0049, 16'shffe8, 16'sh0026, 16'shffb3, 16'sh005a},
		'{16'sh0072, 16'sh0008, 16'shffcd, 16'sh0051, 16'sh001e,
			16'shff92, 16'sh0067, 16'sh0030, 16'shfff4, 16'shffa9},
		'{16'shffe2, 16'shff87, 16'sh0041, 16'sh006c, 16'sh0015,
			16'sh0023, 16'shffbc, 16'sh0059, 16'sh0038, 16'shffd1},
		'{16'sh0027, 16'sh0054, 16'shff9a, 16'shffee, 16'sh0069,
			16'sh0010, 16'sh0032, 16'shff85, 16'sh004b, 16'sh001c},
		'{16'shff98, 16'sh0019, 16'sh0061, 16'sh003a, 16'shffc7,
			16'sh0057, 16'sh0004, 16'sh0046, 16'shffdd, 16'sh002f},
		'{16'sh004f, 16'shffd9, 16'sh0028, 16'shffb0, 16'sh0074,
			16'shffe5, 16'sh003c, 16'sh0013, 16'sh0062, 16'shff90},
		'{16'sh0006, 16'sh0048, 16'shffa6, 16'sh0053, 16'shffca,
			16'sh006e, 16'sh0029, 16'shffbf, 16'sh0011, 16'sh0066},
		'{16'shffb7, 16'sh0031, 16'sh005e, 16'shffe0, 16'sh0040,
			16'shff95, 16'sh001b, 16'sh0075, 16'sh0037, 16'shffcc},
		'{16'sh0060, 16'shffeb, 16'sh0014, 16'sh0047, 16'shff8f,
			16'sh002b, 16'sh0055, 16'shffd3, 16'shffa0, 16'sh0042}
	};

	localparam activationT hiddenBias [numHidden] = '{
		16'sh0010, 16'shffe8, 16'sh0020, 16'sh0008, 16'shfff0,
		16'sh0018, 16'sh0000, 16'sh000c, 16'shfff8, 16'sh0014
	};

	// output layer, one row per neuron, one column per hidden neuron
	localparam activationT outputWeights [numOutputs][numHidden] = '{
		'{16'sh0052, 16'shffc4, 16'sh0036, 16'sh0069, 16'shffa8,
			16'sh0024, 16'sh0047, 16'shffde, 16'sh0058, 16'sh0012},
		'{16'shffd0, 16'sh005d, 16'sh0018, 16'shff9c, 16'sh0043,
			16'sh0066, 16'shffe4, 16'sh002e, 16'shffbb, 16'sh0070},
		'{16'sh003f, 16'sh000a, 16'shffb5, 16'sh004c, 16'sh0027,
			16'shffc9, 16'sh0061, 16'sh0033, 16'sh0005, 16'shffa3},
		'{16'shff9f, 16'sh0045, 16'sh0068, 16'sh001d, 16'shffd7,
			16'sh0050, 16'sh000e, 16'shff93, 16'sh0039, 16'sh005b}
	};

	localparam activationT outputBias [numOutputs] = '{
		16'sh0008, 16'sh0010, 16'shfffc, 16'sh0004
	};

	// ############################################################
	// register map and host bus
	// ############################################################

	localparam int addrWidth = 8;
	localparam int axiDataWidth = 32;

	// ten input words from here, low 16 bits used
	localparam logic [addrWidth-1:0] inputBase = 8'h00;
	// bit 0 starts an inference
	localparam logic [addrWidth-1:0] controlAddr = 8'h40;
	// bit 0 busy, bit 1 done, done clears on read
	localparam logic [addrWidth-1:0] statusAddr = 8'h44;
	// four read-only result words
	localparam logic [addrWidth-1:0] outputBase = 8'h80;

	localparam logic [1:0] respOkay = 2'b00;

	// driven by the host
	typedef struct packed {
		logic [addrWidth-1:0] awaddr;
		logic awvalid;
		logic [axiDataWidth-1:0] wdata;
		logic [axiDataWidth/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [addrWidth-1:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReqT;

	// driven by the register block
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [axiDataWidth-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteRspT;

endpackage

// ==== denseLayer/neuronNode.sv ====
module neuronNode import nnPkg::*; #(
	parameter int layerIdx = 0,
	parameter int nodeIdx = 0
) (
	input logic clk,
	input logic reset,
	input activationVecT inVec,
	output activationT N
);

	localparam int fanIn = (layerIdx == 0) ? numInputs : numHidden;

	activationT inReg [fanIn];
	activationT prod [fanIn];
	activationT bias;
	activationT acc;
	activationT sumReg;

	// rescaled products, only the branch of this layer is elaborated
	for (genvar i = 0; i < fanIn; i++)
	begin : genProd
		logic signed [2*dataWidth-1:0] full;
		if (layerIdx == 0)
		begin : genHidden
			assign full = inReg[i] * hiddenWeights[nodeIdx][i];
		end
		else
		begin : genOutput
			assign full = inReg[i] * outputWeights[nodeIdx][i];
		end
		assign prod[i] = activationT'(full >>> fracBits);
	end

	if (layerIdx == 0)
	begin : genHiddenBias
		assign bias = hiddenBias[nodeIdx];
	end
	else
	begin : genOutputBias
		assign bias = outputBias[nodeIdx];
	end

	// wraps in 16 bits
	always_comb
	begin
		acc = bias;
		for (int i = 0; i < fanIn; i++)
			acc = acc + prod[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < fanIn; i++)
				inReg[i] <= '0;
			sumReg <= '0;
			N <= '0;
		end
		else
		begin
			for (int i = 0; i < fanIn; i++)
				inReg[i] <= inVec[i];
			sumReg <= acc;
			// relu
			N <= sumReg[dataWidth-1] ? '0 : sumReg;
		end
	end

endmodule

// ==== denseLayer/denseLayer.sv ====
module denseLayer import nnPkg::*; #(
	parameter int layerIdx = 0
) (
	input logic clk,
	input logic reset,
	input activationVecT inVec,
	input logic inValid,
	output activationVecT outVec,
	output logic outValid
);

	localparam int numNodes = (layerIdx == 0) ? numHidden : numOutputs;
	// matches the register depth of neuronNode
	localparam int pipeDepth = 3;

	logic [pipeDepth-1:0] validPipe;

	// ############################################################
	// neurons
	// ############################################################

	for (genvar n = 0; n < maxFanIn; n++)
	begin : genNode
		if (n < numNodes)
		begin : genActive
			neuronNode #(
				.layerIdx(layerIdx),
				.nodeIdx(n)
			) neuron0 (
				.clk(clk),
				.reset(reset),
				.inVec(inVec),
				.N(outVec[n])
			);
		end
		else
		begin : genIdle
			// lane past the layer width
			assign outVec[n] = '0;
		end
	end

	// ############################################################
	// valid pipeline
	// ############################################################

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[pipeDepth-2:0], inValid};
	end

	assign outValid = validPipe[pipeDepth-1];

endmodule

// ==== rtl/axiLiteRegs.sv ====
module axiLiteRegs import nnPkg::*; (
	input logic clk,
	input logic reset,
	input axiLiteReqT axiReq,
	output axiLiteRspT axiRsp,
	output activationVecT inVec,
	output logic inValid,
	input activationVecT resVec,
	input logic resValid
);

	logic wrReady;
	logic bValid;
	logic rValid;
	logic [axiDataWidth-1:0] rData;
	logic [axiDataWidth-1:0] rdWord;
	logic busy;
	logic done;
	logic wrFire;
	logic rdFire;
	logic startReq;
	activationT resRegs [numOutputs];

	function automatic logic inRange(
		logic [addrWidth-1:0] addr,
		logic [addrWidth-1:0] base,
		int count
	);
		return (addr >= base) && (addr < base + 4 * count);
	endfunction

	function automatic int wordIdx(logic [addrWidth-1:0] addr, logic [addrWidth-1:0] base);
		return int'((addr - base) >> 2);
	endfunction

	// ############################################################
	// write address, data and response
	// ############################################################

	assign wrFire = wrReady && axiReq.awvalid && axiReq.wvalid;
	assign startReq = wrFire && (axiReq.awaddr == controlAddr)
		&& axiReq.wstrb[0] && axiReq.wdata[0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrReady <= 1'b0;
			bValid <= 1'b0;
		end
		else
		begin
			// one-cycle ready, never while a response waits
			wrReady <= axiReq.awvalid && axiReq.wvalid && !bValid && !wrReady;
			if (wrFire)
				bValid <= 1'b1;
			else if (axiReq.bready)
				bValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			inVec <= '0;
		else if (wrFire && inRange(axiReq.awaddr, inputBase, numInputs))
		begin
			if (axiReq.wstrb[0])
				inVec[wordIdx(axiReq.awaddr, inputBase)][7:0] <= axiReq.wdata[7:0];
			if (axiReq.wstrb[1])
				inVec[wordIdx(axiReq.awaddr, inputBase)][15:8] <= axiReq.wdata[15:8];
		end
	end

	// ############################################################
	// control, status and results
	// ############################################################

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			// start is dropped while an inference runs
			inValid <= startReq && !busy;
			if (startReq && !busy)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (resValid)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			else if (rdFire && axiReq.araddr == statusAddr)
				done <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int j = 0; j < numOutputs; j++)
				resRegs[j] <= '0;
		end
		else if (resValid)
		begin
			for (int j = 0; j < numOutputs; j++)
				resRegs[j] <= resVec[j];
		end
	end

	// ############################################################
	// read channel
	// ############################################################

	assign rdFire = axiReq.arvalid && !rValid;

	// unmapped addresses and the control word read as zero
	always_comb
	begin
		rdWord = '0;
		if (inRange(axiReq.araddr, inputBase, numInputs))
			rdWord[dataWidth-1:0] = inVec[wordIdx(axiReq.araddr, inputBase)];
		else if (inRange(axiReq.araddr, outputBase, numOutputs))
			rdWord[dataWidth-1:0] = resRegs[wordIdx(axiReq.araddr, outputBase)];
		else if (axiReq.araddr == statusAddr)
			rdWord[1:0] = {done, busy};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rValid <= 1'b0;
			rData <= '0;
		end
		else if (rdFire)
		begin
			rValid <= 1'b1;
			rData <= rdWord;
		end
		else if (axiReq.rready)
			rValid <= 1'b0;
	end

	always_comb
	begin
		axiRsp.awready = wrReady;
		axiRsp.wready = wrReady;
		axiRsp.bresp = respOkay;
		axiRsp.bvalid = bValid;
		axiRsp.arready = !rValid;
		axiRsp.rdata = rData;
		axiRsp.rresp = respOkay;
		axiRsp.rvalid = rValid;
	end

endmodule

// ==== rtl/nnAccel.sv ====
module nnAccel import nnPkg::*; (
	input logic clk,
	input logic reset,
	input axiLiteReqT axiReq,
	output axiLiteRspT axiRsp
);

	activationVecT inVec;
	activationVecT hiddenVec;
	activationVecT resVec;
	logic inValid;
	logic hiddenValid;
	logic resValid;

	// host registers
	axiLiteRegs regs0 (
		.clk(clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.inVec(inVec),
		.inValid(inValid),
		.resVec(resVec),
		.resValid(resValid)
	);

	// ten inputs to ten hidden neurons
	denseLayer #(
		.layerIdx(0)
	) hiddenLayer0 (
		.clk(clk),
		.reset(reset),
		.inVec(inVec),
		.inValid(inValid),
		.outVec(hiddenVec),
		.outValid(hiddenValid)
	);

	// ten hidden neurons to four outputs
	denseLayer #(
		.layerIdx(1)
	) outLayer0 (
		.clk(clk),
		.reset(reset),
		.inVec(hiddenVec),
		.inValid(hiddenValid),
		.outVec(resVec),
		.outValid(resValid)
	);

endmodule

// ==== sim/nnModel.svh ====
`ifndef nnModelSvh
`define nnModelSvh

// ############################################################
// Q8.8 reference of the two-layer network
// ############################################################

// full product, arithmetic shift by the fraction, low 16 bits kept
function automatic activationT qProduct(activationT a, activationT w);
	int full;
	full = int'(a) * int'(w);
	full = full >>> fracBits;
	return full[dataWidth-1:0];
endfunction

function automatic activationT rectify(activationT s);
	return s[dataWidth-1] ? activationT'(0) : s;
endfunction

// layer 0 is hidden, layer 1 is output; unused lanes are zero
function automatic activationVecT modelLayer(int layer, activationVecT x);
	activationVecT y;
	activationT sum;
	int nodes;
	int fanIn;
	y = '0;
	nodes = (layer == 0) ? numHidden : numOutputs;
	fanIn = (layer == 0) ? numInputs : numHidden;
	for (int n = 0; n < nodes; n++)
	begin
		sum = (layer == 0) ? hiddenBias[n] : outputBias[n];
		for (int i = 0; i < fanIn; i++)
		begin
			// sum wraps in 16 bits
			if (layer == 0)
				sum = sum + qProduct(x[i], hiddenWeights[n][i]);
			else
				sum = sum + qProduct(x[i], outputWeights[n][i]);
		end
		y[n] = rectify(sum);
	end
	return y;
endfunction

function automatic activationVecT modelNetwork(activationVecT x);
	return modelLayer(1, modelLayer(0, x));
endfunction

`endif

// ==== sim/tbNnAccel.sv ====
module tbNnAccel import nnPkg::*; ();

	localparam int numVectors = 50;
	// one 200-cycle slot per inference plus one for the register tests
	localparam int cycleLimit = (numVectors + 2) * 200;

	logic clk;
	logic reset;
	axiLiteReqT axiReq;
	axiLiteRspT axiRsp;

	logic [31:0] seed;
	logic stallsOn;
	int cycles = 0;

	`include "nnModel.svh"

	nnAccel dut0 (
		.clk(clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("timeout waiting for done after %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// ############################################################
	// random numbers and checks
	// ############################################################

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// magnitude below 4.0 in Q8.8
	function automatic activationT randomActivation();
		logic [31:0] r;
		activationT mag;
		r = nextRand();
		mag = activationT'({6'b0, r[25:16]});
		return r[31] ? -mag : mag;
	endfunction

	function automatic logic readyChoice();
		logic [31:0] r;
		if (!stallsOn)
			return 1'b1;
		r = nextRand();
		return r[29];
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ############################################################
	// AXI4-Lite host
	// ############################################################

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
		logic seen;
		logic hs;
		logic rdy;
		axiReq.awaddr = addr;
		axiReq.awvalid = 1'b1;
		axiReq.wdata = data;
		axiReq.wstrb = 4'hf;
		axiReq.wvalid = 1'b1;
		// ready seen at a falling edge means the transfer is on the next rising edge
		do
		begin
			seen = axiRsp.awready && axiRsp.wready;
			@(negedge clk);
		end while (!seen);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		do
		begin
			rdy = readyChoice();
			hs = axiRsp.bvalid && rdy;
			if (hs)
				checkValue("bresp", 32'(axiRsp.bresp), 32'(respOkay));
			axiReq.bready = rdy;
			@(negedge clk);
		end while (!hs);
		axiReq.bready = 1'b0;
	endtask

	task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
		logic seen;
		logic hs;
		logic rdy;
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		do
		begin
			seen = axiRsp.arready;
			@(negedge clk);
		end while (!seen);
		axiReq.arvalid = 1'b0;
		do
		begin
			rdy = readyChoice();
			hs = axiRsp.rvalid && rdy;
			if (hs)
			begin
				data = axiRsp.rdata;
				checkValue("rresp", 32'(axiRsp.rresp), 32'(respOkay));
			end
			axiReq.rready = rdy;
			@(negedge clk);
		end while (!hs);
		axiReq.rready = 1'b0;
	endtask

	task automatic expectRead(string name, logic [7:0] addr, logic [31:0] exp);
		logic [31:0] got;
		readReg(addr, got);
		checkValue(name, got, exp);
	endtask

	// ############################################################
	// one inference
	// ############################################################

	task automatic runVector(activationVecT x, logic startTwice);
		activationVecT expected;
		logic [31:0] st;
		for (int i = 0; i < numInputs; i++)
			writeReg(inputBase + 8'(4 * i), {16'h0, x[i]});
		writeReg(controlAddr, 32'h1);
		// lands while the first inference still runs
		if (startTwice)
			writeReg(controlAddr, 32'h1);
		do
		begin
			readReg(statusAddr, st);
			// busy until the results land
			if (!st[1])
				checkValue("status while running", st, 32'h1);
		end while (!st[1]);
		checkValue("status at done", st, 32'h2);
		expectRead("status after done", statusAddr, 32'h0);
		expected = modelNetwork(x);
		for (int j = 0; j < numOutputs; j++)
		begin
			readReg(outputBase + 8'(4 * j), st);
			checkValue($sformatf("result%0d sign", j), 32'(st[dataWidth-1]), 32'h0);
			checkValue($sformatf("result%0d", j), st, {16'h0, expected[j]});
		end
		if (startTwice)
		begin
			// an accepted second start would set done again by now
			repeat (20) @(negedge clk);
			expectRead("status after ignored start", statusAddr, 32'h0);
		end
	endtask

	initial
	begin
		activationVecT x;
		logic [31:0] r;
		seed = 32'h6087cec4;
		stallsOn = 1'b1;
		reset = 1'b1;
		axiReq = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		expectRead("status", statusAddr, 32'h0);
		for (int j = 0; j < numOutputs; j++)
			expectRead($sformatf("result%0d", j), outputBase + 8'(4 * j), 32'h0);

		// upper half of each input word is dropped
		for (int i = 0; i < numInputs; i++)
		begin
			r = nextRand();
			writeReg(inputBase + 8'(4 * i), r);
			expectRead($sformatf("input%0d", i), inputBase + 8'(4 * i), {16'h0, r[15:0]});
		end
		expectRead("unmapped 0x28", 8'h28, 32'h0);
		expectRead("unmapped 0x48", 8'h48, 32'h0);
		expectRead("unmapped 0x90", 8'h90, 32'h0);
		expectRead("unmapped 0xfc", 8'hfc, 32'h0);

		for (int v = 0; v < numVectors; v++)
		begin
			x = '0;
			for (int i = 0; i < numInputs; i++)
				x[i] = randomActivation();
			runVector(x, 1'b0);
		end

		// no stalls, so the second start is sure to hit a busy engine
		stallsOn = 1'b0;
		x = '0;
		for (int i = 0; i < numInputs; i++)
			x[i] = randomActivation();
		runVector(x, 1'b1);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+sim
common/nnPkg.sv
denseLayer/neuronNode.sv
denseLayer/denseLayer.sv
rtl/axiLiteRegs.sv
rtl/nnAccel.sv
sim/tbNnAccel.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tbNnAccel
FILELIST = files.f
OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
